// File: rtl/cart_pkg.sv
/*
 * cartridge loader package
 * widths and types for loader bytes, cartridge words and bus accesses,
 * the ROM loading code and the bus access-size codes
 */

package cart_pkg;

    ////////////////////
    // widths and types
    ////////////////////

    localparam int ROM_ADDR_W = 10;

    // one byte from the loader stream
    typedef logic [7:0] byte_t;

    // one cartridge word, lane 0 in bits 7:0
    typedef logic [31:0] word_t;

    // byte-lane enables of a bus access
    typedef logic [3:0] lane_en_t;

    // word address inside the store
    typedef logic [ROM_ADDR_W-1:0] word_addr_t;

    // bus byte address, two extra bits select the lane
    typedef logic [ROM_ADDR_W+1:0] bus_addr_t;

    typedef logic [1:0] acc_size_t;

    ////////////////////
    // codes
    ////////////////////

    // loading code for a ROM image, all other codes are ignored
    localparam logic [2:0] LOAD_ROM = 3'd1;

    localparam acc_size_t ACC_BYTE = 2'd0;
    localparam acc_size_t ACC_HALF = 2'd1;
    localparam acc_size_t ACC_WORD = 2'd2;
    localparam acc_size_t ACC_NONE = 2'd3;

endpackage

// File: rtl/word_xfer_if.sv
/*
 * one addressed cartridge word moving between two stages
 * four-phase req/ack, sender and receiver modports
 */
`timescale 1ns/1ps

interface word_xfer_if;

    logic                 req;
    logic                 ack;
    cart_pkg::word_addr_t addr;
    cart_pkg::word_t      data;
    // marks the final word of a load
    logic                 last;

    modport sender (
        output req,
        output addr,
        output data,
        output last,
        input  ack
    );

    modport receiver (
        input  req,
        input  addr,
        input  data,
        input  last,
        output ack
    );

endinterface

// File: rtl/loader_packer.sv
/*
 * loader byte packer
 * little-endian word assembly with one word held back to tag the last
 * word of a load, and the four-phase sender FSM
 */
`timescale 1ns/1ps

module loader_packer (
    input  logic            clk16,
    input  logic            resetn,
    input  logic [2:0]      loading,
    input  cart_pkg::byte_t loader_do,
    input  logic            loader_do_valid,
    output logic            load_start,
    word_xfer_if.sender     xfer
);

    typedef enum logic [1:0] {
        IDLE,
        COLLECT,
        SEND,
        WAIT_ACK_LOW
    } pack_state_t;

    pack_state_t          state;
    logic                 in_rom;
    logic                 in_rom_q;
    logic                 load_end;
    logic                 byte_in;
    logic                 word_done;
    logic [1:0]           byte_cnt;
    logic [1:0]           lane_idx;
    cart_pkg::word_t      asm_data;
    cart_pkg::word_addr_t word_cnt;
    cart_pkg::word_t      hold_data;
    cart_pkg::word_addr_t hold_addr;
    logic                 hold_valid;
    logic                 release_pend;
    logic                 end_pend;
    logic                 end_clear;
    logic                 send_hold;
    logic                 send_tail;
    cart_pkg::word_t      tx_data;
    cart_pkg::word_addr_t tx_addr;
    logic                 tx_last;

    assign in_rom     = (loading == cart_pkg::LOAD_ROM);
    assign load_start = in_rom && !in_rom_q;
    assign load_end   = in_rom_q && !in_rom;
    assign byte_in    = loader_do_valid && in_rom;

    // a new load always starts in lane 0
    assign lane_idx  = load_start ? 2'd0 : byte_cnt;
    assign word_done = byte_in && (lane_idx == 2'd3);

    // held word goes out once a later byte shows up or the load ends
    assign send_hold = (state == COLLECT) && hold_valid && (release_pend || end_pend);
    assign send_tail = (state == COLLECT) && end_pend && !hold_valid && (byte_cnt != 2'd0);
    assign end_clear = (state == COLLECT) && end_pend && (byte_cnt == 2'd0 || !hold_valid);

    ////////////////////
    // byte assembly
    ////////////////////

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            in_rom_q     <= 1'b0;
            byte_cnt     <= 2'd0;
            word_cnt     <= '0;
            hold_valid   <= 1'b0;
            release_pend <= 1'b0;
            end_pend     <= 1'b0;
        end else begin
            in_rom_q <= in_rom;
            if (byte_in) begin
                byte_cnt <= lane_idx + 2'd1;
            end else if (load_start || send_tail) begin
                byte_cnt <= 2'd0;
            end
            if (load_start) begin
                word_cnt <= '0;
            end else if (word_done) begin
                word_cnt <= word_cnt + 1'b1;
            end
            if (word_done) begin
                hold_valid <= 1'b1;
            end else if (load_start || send_hold) begin
                hold_valid <= 1'b0;
            end
            if (byte_in && hold_valid && !load_start) begin
                release_pend <= 1'b1;
            end else if (load_start || send_hold) begin
                release_pend <= 1'b0;
            end
            if (load_end) begin
                end_pend <= 1'b1;
            end else if (load_start || end_clear) begin
                end_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk16) begin
        // cleared lanes give the zero padding of a short tail word
        if (load_start || word_done) begin
            asm_data <= '0;
        end
        if (byte_in && !word_done) begin
            asm_data[8*lane_idx +: 8] <= loader_do;
        end
        if (word_done) begin
            hold_data <= {loader_do, asm_data[23:0]};
            hold_addr <= word_cnt;
        end
        if (send_hold) begin
            tx_data <= hold_data;
            tx_addr <= hold_addr;
            tx_last <= end_pend && (byte_cnt == 2'd0);
        end else if (send_tail) begin
            tx_data <= asm_data;
            tx_addr <= word_cnt;
            tx_last <= 1'b1;
        end
    end

    ////////////////////
    // sender FSM
    ////////////////////

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (load_start) begin
                        state <= COLLECT;
                    end
                end
                COLLECT: begin
                    if (send_hold || send_tail) begin
                        state <= SEND;
                    end else if (!in_rom && !in_rom_q && !end_pend && !hold_valid) begin
                        state <= IDLE;
                    end
                end
                SEND: begin
                    if (xfer.ack) begin
                        state <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW: begin
                    if (!xfer.ack) begin
                        state <= COLLECT;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign xfer.req  = (state == SEND);
    assign xfer.addr = tx_addr;
    assign xfer.data = tx_data;
    assign xfer.last = tx_last;

endmodule

// File: rtl/load_fifo.sv
/*
 * circular buffer of addressed words
 * four-phase receiver on the input, four-phase sender FSM on the output
 */
`timescale 1ns/1ps

module load_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic          clk16,
    input  logic          resetn,
    word_xfer_if.receiver in_xfer,
    word_xfer_if.sender   out_xfer
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    typedef enum logic [1:0] {
        OUT_IDLE,
        OUT_REQ,
        OUT_WAIT_LOW
    } out_state_t;

    cart_pkg::word_addr_t mem_addr [FIFO_DEPTH];
    cart_pkg::word_t      mem_data [FIFO_DEPTH];
    logic                 mem_last [FIFO_DEPTH];

    // one extra pointer bit tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           empty;
    logic           in_ack;
    logic           wr_en;
    out_state_t     out_state;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    ////////////////////
    // input side
    ////////////////////

    // ack is held off while full
    assign wr_en = in_xfer.req && !in_ack && !full;

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            in_ack <= 1'b0;
            wr_ptr <= '0;
        end else begin
            if (wr_en) begin
                in_ack <= 1'b1;
                wr_ptr <= wr_ptr + 1'b1;
            end else if (in_ack && !in_xfer.req) begin
                in_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk16) begin
        if (wr_en) begin
            mem_addr[wr_ptr[PTR_W-1:0]] <= in_xfer.addr;
            mem_data[wr_ptr[PTR_W-1:0]] <= in_xfer.data;
            mem_last[wr_ptr[PTR_W-1:0]] <= in_xfer.last;
        end
    end

    assign in_xfer.ack = in_ack;

    ////////////////////
    // output side
    ////////////////////

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            out_state <= OUT_IDLE;
            rd_ptr    <= '0;
        end else begin
            case (out_state)
                OUT_IDLE: begin
                    if (!empty) begin
                        out_state <= OUT_REQ;
                    end
                end
                OUT_REQ: begin
                    if (out_xfer.ack) begin
                        rd_ptr    <= rd_ptr + 1'b1;
                        out_state <= OUT_WAIT_LOW;
                    end
                end
                OUT_WAIT_LOW: begin
                    // next entry may go as soon as ack has dropped
                    if (!out_xfer.ack) begin
                        out_state <= empty ? OUT_IDLE : OUT_REQ;
                    end
                end
                default: out_state <= OUT_IDLE;
            endcase
        end
    end

    // head entry stays put until its ack
    assign out_xfer.req  = (out_state == OUT_REQ);
    assign out_xfer.addr = mem_addr[rd_ptr[PTR_W-1:0]];
    assign out_xfer.data = mem_data[rd_ptr[PTR_W-1:0]];
    assign out_xfer.last = mem_last[rd_ptr[PTR_W-1:0]];

endmodule

// File: rtl/cart_rom_store.sv
/*
 * cartridge word store
 * handshake write port, gbaon flag, byte-enable bus read port
 */
`timescale 1ns/1ps

module cart_rom_store (
    input  logic                clk16,
    input  logic                resetn,
    input  logic                load_start,
    word_xfer_if.receiver       xfer,
    input  cart_pkg::bus_addr_t bus_addr,
    input  cart_pkg::acc_size_t bus_size,
    input  logic                bus_ena,
    output cart_pkg::word_t     bus_rdata,
    output logic                bus_done,
    output logic                gbaon
);

    localparam int ROM_WORDS = 2 ** cart_pkg::ROM_ADDR_W;

    cart_pkg::word_t      rom [ROM_WORDS];
    logic                 wr_ack;
    logic                 wr_en;
    cart_pkg::word_addr_t rd_addr;
    cart_pkg::lane_en_t   lane_en;
    cart_pkg::word_t      lane_mask;

    ////////////////////
    // write port
    ////////////////////

    // take the word on the first cycle req is seen
    assign wr_en = xfer.req && !wr_ack;

    always_ff @(posedge clk16) begin
        if (wr_en) begin
            rom[xfer.addr] <= xfer.data;
        end
    end

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            wr_ack <= 1'b0;
            gbaon  <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ack <= 1'b1;
            end else if (wr_ack && !xfer.req) begin
                wr_ack <= 1'b0;
            end
            // console stays off for the whole load
            if (load_start) begin
                gbaon <= 1'b0;
            end else if (wr_en && xfer.last) begin
                gbaon <= 1'b1;
            end
        end
    end

    assign xfer.ack = wr_ack;

    ////////////////////
    // read port
    ////////////////////

    assign rd_addr = bus_addr[cart_pkg::ROM_ADDR_W+1:2];

    always_comb begin
        case (bus_size)
            cart_pkg::ACC_BYTE: lane_en = cart_pkg::lane_en_t'(4'b0001 << bus_addr[1:0]);
            cart_pkg::ACC_HALF: lane_en = bus_addr[1] ? 4'b1100 : 4'b0011;
            cart_pkg::ACC_WORD: lane_en = 4'b1111;
            cart_pkg::ACC_NONE: lane_en = 4'b0000;
        endcase
    end

    // each enable widened to a full byte
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_mask[8*i +: 8] = {8{lane_en[i]}};
        end
    end

    always_ff @(posedge clk16) begin
        if (bus_ena) begin
            bus_rdata <= rom[rd_addr] & lane_mask;
        end
    end

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            bus_done <= 1'b0;
        end else begin
            bus_done <= bus_ena;
        end
    end

endmodule

// File: rtl/cart_loader_top.sv
/*
 * cartridge loader top level
 * packer, word buffer and cartridge store joined by two word links
 */
`timescale 1ns/1ps

module cart_loader_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk16,
    input  logic                resetn,
    input  logic [2:0]          loading,
    input  cart_pkg::byte_t     loader_do,
    input  logic                loader_do_valid,
    input  cart_pkg::bus_addr_t bus_addr,
    input  cart_pkg::acc_size_t bus_size,
    input  logic                bus_ena,
    output cart_pkg::word_t     bus_rdata,
    output logic                bus_done,
    output logic                gbaon
);

    logic load_start;

    word_xfer_if pack_xfer ();
    word_xfer_if store_xfer ();

    loader_packer packer_i (
        .clk16           (clk16),
        .resetn          (resetn),
        .loading         (loading),
        .loader_do       (loader_do),
        .loader_do_valid (loader_do_valid),
        .load_start      (load_start),
        .xfer            (pack_xfer.sender)
    );

    load_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk16    (clk16),
        .resetn   (resetn),
        .in_xfer  (pack_xfer.receiver),
        .out_xfer (store_xfer.sender)
    );

    cart_rom_store store_i (
        .clk16      (clk16),
        .resetn     (resetn),
        .load_start (load_start),
        .xfer       (store_xfer.receiver),
        .bus_addr   (bus_addr),
        .bus_size   (bus_size),
        .bus_ena    (bus_ena),
        .bus_rdata  (bus_rdata),
        .bus_done   (bus_done),
        .gbaon      (gbaon)
    );

endmodule

// File: dv/cart_loader_assertions.sv
/*
 * handshake and reset assertions for the cartridge loader
 * four-phase rules on both word links, gbaon after reset
 */
`timescale 1ns/1ps

module cart_loader_assertions (
    input logic clk16,
    input logic resetn,
    input logic gbaon,
    input logic pack_req,
    input logic pack_ack,
    input logic store_req,
    input logic store_ack
);

    ////////////////////
    // four-phase links
    ////////////////////

    // req holds until the receiver answers
    pack_req_held: assert property (
        @(posedge clk16) disable iff (!resetn) pack_req && !pack_ack |=> pack_req
    ) else $error("packer req dropped before ack");

    store_req_held: assert property (
        @(posedge clk16) disable iff (!resetn) store_req && !store_ack |=> store_req
    ) else $error("buffer req dropped before ack");

    pack_ack_needs_req: assert property (
        @(posedge clk16) disable iff (!resetn) $rose(pack_ack) |-> pack_req
    ) else $error("buffer ack rose without req");

    store_ack_needs_req: assert property (
        @(posedge clk16) disable iff (!resetn) $rose(store_ack) |-> store_req
    ) else $error("store ack rose without req");

    // console is off once reset has been seen
    gbaon_reset_low: assert property (
        @(posedge clk16) !resetn |=> !gbaon
    ) else $error("gbaon high after reset");

endmodule

// File: dv/cart_loader_tb.sv
/*
 * cartridge loader testbench
 * clock and reset, pattern file reader, load and bus read stimulus,
 * value checks and a watchdog
 */
`timescale 1ns/1ps

module cart_loader_tb;

    localparam string       PATTERN_FILE = "dv/cart_patterns.txt";
    localparam logic [31:0] SEED         = 32'hc546_d64c;
    localparam int          GBAON_WAIT   = 200;

    logic                clk16;
    logic                resetn;
    logic [2:0]          loading;
    cart_pkg::byte_t     loader_do;
    logic                loader_do_valid;
    cart_pkg::bus_addr_t bus_addr;
    cart_pkg::acc_size_t bus_size;
    logic                bus_ena;
    cart_pkg::word_t     bus_rdata;
    logic                bus_done;
    logic                gbaon;

    int          errors         = 0;
    int          n_checks       = 0;
    int          watchdog_cycles = 0;
    logic        watchdog_armed = 1'b0;
    logic [7:0]  rec_kind [$];
    logic [31:0] rec_a [$];
    logic [31:0] rec_b [$];
    logic [31:0] rec_c [$];

    cart_loader_top #(
        .FIFO_DEPTH (4)
    ) dut_i (
        .clk16           (clk16),
        .resetn          (resetn),
        .loading         (loading),
        .loader_do       (loader_do),
        .loader_do_valid (loader_do_valid),
        .bus_addr        (bus_addr),
        .bus_size        (bus_size),
        .bus_ena         (bus_ena),
        .bus_rdata       (bus_rdata),
        .bus_done        (bus_done),
        .gbaon           (gbaon)
    );

    bind cart_loader_top cart_loader_assertions assert_i (
        .clk16     (clk16),
        .resetn    (resetn),
        .gbaon     (gbaon),
        .pack_req  (pack_xfer.req),
        .pack_ack  (pack_xfer.ack),
        .store_req (store_xfer.req),
        .store_ack (store_xfer.ack)
    );

    initial begin
        clk16 = 1'b0;
        forever #5 clk16 = ~clk16;
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, got);
        end
    endtask

    task automatic read_patterns();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the pattern file %s", PATTERN_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            if (kind == "L") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                c = 32'h0;
            end else if (kind == "R") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
            end else begin
                n = -1;
            end
            // comment and blank lines give n of -1
            if (n >= 0 && n != ((kind == "L") ? 2 : 3)) begin
                errors++;
                $display("malformed pattern record: %s", line);
            end else if (n > 0) begin
                rec_kind.push_back(kind);
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // starts and ends on a rising edge, two cycles long
    task automatic bus_read(input cart_pkg::bus_addr_t addr, input cart_pkg::acc_size_t size,
                            output cart_pkg::word_t data);
        bus_addr <= addr;
        bus_size <= size;
        bus_ena  <= 1'b1;
        @(negedge clk16);
        check_value("bus_done", 32'h0, 32'(bus_done));
        @(posedge clk16);
        bus_ena <= 1'b0;
        @(negedge clk16);
        check_value("bus_done", 32'h1, 32'(bus_done));
        data = bus_rdata;
        @(posedge clk16);
    endtask

    task automatic send_byte(input cart_pkg::byte_t value, input int gap,
                             input logic with_read);
        cart_pkg::word_t unused_data;
        loader_do       <= value;
        loader_do_valid <= 1'b1;
        @(negedge clk16);
        check_value("gbaon", 32'h0, 32'(gbaon));
        @(posedge clk16);
        loader_do_valid <= 1'b0;
        // a read squeezed into the gap, only its timing is checked
        if (with_read) begin
            bus_read('0, cart_pkg::ACC_WORD, unused_data);
            repeat (gap - 2) @(posedge clk16);
        end else begin
            repeat (gap) @(posedge clk16);
        end
    endtask

    task automatic run_load(input int count, input cart_pkg::byte_t start);
        int gap;
        int waited;
        loading <= cart_pkg::LOAD_ROM;
        @(posedge clk16);
        @(negedge clk16);
        // console off from the first ROM loading cycle
        check_value("gbaon", 32'h0, 32'(gbaon));
        @(posedge clk16);
        for (int i = 0; i < count; i++) begin
            gap = 2 + int'($urandom % 4);
            send_byte(cart_pkg::byte_t'(int'(start) + i), gap, (i % 5) == 2);
        end
        loading <= 3'd0;
        waited = 0;
        @(negedge clk16);
        while (!gbaon && waited < GBAON_WAIT) begin
            @(negedge clk16);
            waited++;
        end
        if (!gbaon) begin
            errors++;
            $display("gbaon did not rise within %0d cycles after the load ended", GBAON_WAIT);
        end
        @(posedge clk16);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin : main
        int              total_bytes;
        int              total_reads;
        int              n_loads;
        cart_pkg::word_t got;
        resetn          = 1'b0;
        loading         = 3'd0;
        loader_do       = '0;
        loader_do_valid = 1'b0;
        bus_addr        = '0;
        bus_size        = '0;
        bus_ena         = 1'b0;
        void'($urandom(SEED));
        read_patterns();
        if (rec_kind.size() == 0) begin
            errors++;
            $display("the pattern file holds no records");
        end
        total_bytes = 0;
        total_reads = 0;
        n_loads     = 0;
        foreach (rec_kind[k]) begin
            if (rec_kind[k] == "L") begin
                total_bytes += int'(rec_a[k]);
                n_loads++;
            end else begin
                total_reads++;
            end
        end
        watchdog_cycles = total_bytes * 6 + total_reads * 4 + n_loads * (GBAON_WAIT + 8) + 100;
        watchdog_armed  = 1'b1;

        repeat (4) @(posedge clk16);
        resetn <= 1'b1;
        @(negedge clk16);
        check_value("gbaon", 32'h0, 32'(gbaon));
        @(posedge clk16);

        foreach (rec_kind[k]) begin
            if (rec_kind[k] == "L") begin
                run_load(int'(rec_a[k]), cart_pkg::byte_t'(rec_b[k]));
            end else begin
                bus_read(cart_pkg::bus_addr_t'(rec_a[k]), cart_pkg::acc_size_t'(rec_b[k]), got);
                check_value($sformatf("bus_rdata @%h size %0d", rec_a[k], rec_b[k]),
                            rec_c[k], got);
            end
        end

        $display("checks %0d, errors %0d", n_checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_armed);
        repeat (watchdog_cycles) @(posedge clk16);
        $display("run timed out after %0d cycles before the patterns were done", watchdog_cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: dv/cart_patterns.txt
# L <byte count> <start byte>             load bytes start, start+1, ... modulo 256
# R <bus address> <size> <expected data>  size 0 byte, 1 half, 2 word, 3 none; all hex
L 20 10
R 000 2 13121110
R 004 2 17161514
R 01c 2 2f2e2d2c
R 001 0 00001100
R 003 0 13000000
R 006 1 17160000
R 008 1 00001918
R 00c 3 00000000
L 0b f8
R 000 2 fbfaf9f8
R 004 2 fffefdfc
R 008 2 00020100
R 00a 0 00020000
R 00b 0 00000000
R 00c 2 1f1e1d1c
R 00e 1 1f1e0000
R 01c 2 2f2e2d2c
L 05 40
R 000 2 43424140
R 004 2 00000044
R 006 1 00000000
R 008 2 00020100

// File: filelist.f
rtl/cart_pkg.sv
rtl/word_xfer_if.sv
rtl/loader_packer.sv
rtl/load_fifo.sv
rtl/cart_rom_store.sv
rtl/cart_loader_top.sv
dv/cart_loader_assertions.sv
dv/cart_loader_tb.sv

// File: Makefile
# Verilator flow for the cartridge loader

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= cart_loader_tb
RTL_TOP    ?= cart_loader_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --assert
SIM_FLAGS  ?= --binary --timing --assert
PASS_TEXT  ?= ** PASS **

RTL_FILES := $(shell grep '^rtl/' $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
